// ==== hdl/lce_defines.svh ====
/*
 * LCE defines. Widths, cache geometry, the id of this LCE and the
 * miss timeout shared by the instruction-cache fill engine.
 */
`ifndef LCE_DEFINES_SVH
`define LCE_DEFINES_SVH

`define LCE_ADDR_WIDTH          32  // physical address.
`define LCE_DATA_WIDTH          64  // one block is one word.
`define LCE_SETS                16
`define LCE_WAYS                2

`define LCE_ID_WIDTH            2
`define LCE_ID                  1   // id carried in outgoing requests.

`define LCE_BLOCK_OFFSET_WIDTH  3   // byte offset within a block.
`define LCE_INDEX_WIDTH         4
`define LCE_WAY_WIDTH           1

// cycles spent waiting for a fill before the miss is abandoned.
`define LCE_TIMEOUT_CYCLES      64

`endif

// ==== hdl/lce_msg_pkg.sv ====
/*
 * LCE message package. Messages carried on the coherence network
 * between this LCE, other LCEs and the directory.
 */
`default_nettype none

`include "lce_defines.svh"

package lce_msg_pkg;

  // miss request sent out when a block must be fetched.
  typedef struct packed {
    logic [`LCE_ADDR_WIDTH-1:0] addr;
    logic [`LCE_WAY_WIDTH-1:0]  way_id;   // victim way to fill.
    logic [`LCE_ID_WIDTH-1:0]   src_id;   // requesting LCE.
  } lce_req_t;

  // transfer response, the block sent by the LCE that owns it.
  typedef struct packed {
    logic [`LCE_ADDR_WIDTH-1:0] addr;
    logic [`LCE_WAY_WIDTH-1:0]  way_id;
    logic [`LCE_DATA_WIDTH-1:0] data;
  } lce_tr_resp_t;

endpackage

`default_nettype wire

// ==== hdl/icache_pkg.sv ====
/*
 * Instruction-cache package. Types internal to the cache: the
 * data-memory write packet and the miss FSM state encoding.
 */
`default_nettype none

`include "lce_defines.svh"

package icache_pkg;

  // one block write into the data memory.
  typedef struct packed {
    logic [`LCE_INDEX_WIDTH-1:0] index;
    logic [`LCE_WAY_WIDTH-1:0]   way_id;
    logic [`LCE_DATA_WIDTH-1:0]  data;
  } data_mem_pkt_t;

  // miss handling states.
  typedef enum logic [1:0] {
    e_idle,       // ready for a new miss.
    e_wait_resp,  // request sent, waiting for the block.
    e_timeout     // one cycle, reports the error.
  } miss_state_e;

endpackage

`default_nettype wire

// ==== hdl/lce_fifo.sv ====
/*
 * Two-entry FIFO with valid/ready on the input side and valid/yumi
 * on the output side. Payload type is a parameter.
 */
`timescale 1ns/1ps
`default_nettype none

module lce_fifo #(
  parameter type elem_t = logic [7:0]
) (
  input  wire logic clk_i,
  input  wire logic arst_n_i,

  input  wire logic  v_i,
  output logic       ready_o,
  input  wire elem_t data_i,

  output logic       v_o,
  input  wire logic  yumi_i,   // pops the head, only with v_o high.
  output elem_t      data_o
);

  elem_t      mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  assign ready_o = (count_q != 2'd2);
  assign v_o     = (count_q != 2'd0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = v_i & ready_o;
  assign pop  = yumi_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + {1'b0, push} - {1'b0, pop};  // push and pop may coincide.
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

`default_nettype wire

// ==== hdl/lce_tr_resp_in.sv ====
/*
 * Transfer-response input. Turns the response at the head of the
 * response FIFO into a data-memory write packet.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lce_defines.svh"

module lce_tr_resp_in
  import lce_msg_pkg::*;
  import icache_pkg::*;
(
  input  wire lce_tr_resp_t lce_tr_resp_i,
  input  wire logic         lce_tr_resp_v_i,
  output logic              lce_tr_resp_yumi_o,

  output logic              data_mem_pkt_v_o,
  output data_mem_pkt_t     data_mem_pkt_o,
  input  wire logic         data_mem_pkt_yumi_i,

  output logic              tr_received_o    // block written this cycle.
);

  logic accepted;

  // set index sits just above the byte offset.
  assign data_mem_pkt_o.index  = lce_tr_resp_i.addr[`LCE_BLOCK_OFFSET_WIDTH +: `LCE_INDEX_WIDTH];
  assign data_mem_pkt_o.way_id = lce_tr_resp_i.way_id;
  assign data_mem_pkt_o.data   = lce_tr_resp_i.data;

  assign data_mem_pkt_v_o = lce_tr_resp_v_i;

  assign accepted           = data_mem_pkt_yumi_i & lce_tr_resp_v_i;
  assign lce_tr_resp_yumi_o = accepted;  // pops the response.
  assign tr_received_o      = accepted;

endmodule

`default_nettype wire

// ==== hdl/lce_timer.sv ====
/*
 * Wait timer. Counts enabled cycles from a start and flags expiry
 * once the miss timeout is reached.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lce_defines.svh"

module lce_timer (
  input  wire logic clk_i,
  input  wire logic arst_n_i,

  input  wire logic start_i,   // clears the count.
  input  wire logic en_i,      // counts this cycle.
  output logic      expired_o
);

  localparam int cnt_width_lp = $clog2(`LCE_TIMEOUT_CYCLES + 1);
  localparam logic [cnt_width_lp-1:0] limit_lp = cnt_width_lp'(`LCE_TIMEOUT_CYCLES);

  logic [cnt_width_lp-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= '0;
    end else if (en_i && (cnt_q != limit_lp)) begin
      cnt_q <= cnt_q + 1'b1;  // saturates at the limit.
    end
  end

  assign expired_o = (cnt_q == limit_lp);

endmodule

`default_nettype wire

// ==== hdl/lce_miss_fsm.sv ====
/*
 * Miss FSM. Accepts a cache miss, pushes one request into the
 * network and waits for the fill or the timeout.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lce_defines.svh"

module lce_miss_fsm
  import lce_msg_pkg::*;
  import icache_pkg::*;
(
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,

  // miss from the cache.
  input  wire logic                       miss_v_i,
  output logic                            miss_ready_o,
  input  wire logic [`LCE_ADDR_WIDTH-1:0] miss_addr_i,
  input  wire logic [`LCE_WAY_WIDTH-1:0]  miss_way_i,

  // push into the request FIFO.
  output logic                            req_v_o,
  input  wire logic                       req_ready_i,
  output lce_req_t                        req_o,

  input  wire logic                       tr_received_i,

  // wait timer.
  output logic                            timer_start_o,
  output logic                            timer_en_o,
  input  wire logic                       timer_expired_i,

  output logic                            fill_done_o,
  output logic                            miss_error_o
);

  miss_state_e state_q;
  miss_state_e state_d;
  logic        miss_accept;
  logic        fill_done_q;
  logic        miss_error_q;

  // a miss only goes through when the request can be queued.
  assign miss_ready_o = (state_q == e_idle) & req_ready_i;
  assign miss_accept  = miss_v_i & miss_ready_o;

  assign req_v_o       = (state_q == e_idle) & miss_v_i;
  assign req_o.addr    = miss_addr_i;
  assign req_o.way_id  = miss_way_i;
  assign req_o.src_id  = `LCE_ID_WIDTH'(`LCE_ID);

  assign timer_start_o = miss_accept;
  assign timer_en_o    = (state_q == e_wait_resp);

  always_comb begin
    state_d = state_q;
    case (state_q)
      e_idle: begin
        if (miss_accept) state_d = e_wait_resp;
      end
      e_wait_resp: begin
        // a fill in the expiry cycle still counts as a fill.
        if (tr_received_i) state_d = e_idle;
        else if (timer_expired_i) state_d = e_timeout;
      end
      e_timeout: state_d = e_idle;
      default: state_d = e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= e_idle;
      fill_done_q  <= 1'b0;
      miss_error_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      fill_done_q  <= (state_q == e_wait_resp) & tr_received_i;  // late fills are silent.
      miss_error_q <= (state_q == e_wait_resp) & ~tr_received_i & timer_expired_i;
    end
  end

  assign fill_done_o  = fill_done_q;
  assign miss_error_o = miss_error_q;  // high during e_timeout.

endmodule

`default_nettype wire

// ==== hdl/icache_data_mem.sv ====
/*
 * Data memory. Single-ported block storage of sets by ways, with a
 * registered read and a packet write that yields to the read.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lce_defines.svh"

module icache_data_mem
  import icache_pkg::*;
(
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,

  input  wire logic                        pkt_v_i,
  input  wire data_mem_pkt_t               pkt_i,
  output logic                             pkt_yumi_o,

  input  wire logic                        rd_v_i,
  input  wire logic [`LCE_INDEX_WIDTH-1:0] rd_index_i,
  input  wire logic [`LCE_WAY_WIDTH-1:0]   rd_way_i,
  output logic [`LCE_DATA_WIDTH-1:0]       rd_data_o
);

  logic [`LCE_DATA_WIDTH-1:0] mem_q [`LCE_SETS][`LCE_WAYS];
  logic [`LCE_DATA_WIDTH-1:0] rd_data_q;

  // one access per cycle, the read wins.
  assign pkt_yumi_o = pkt_v_i & ~rd_v_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < `LCE_SETS; s++) begin
        for (int w = 0; w < `LCE_WAYS; w++) begin
          mem_q[s][w] <= '0;
        end
      end
      rd_data_q <= '0;
    end else if (rd_v_i) begin
      rd_data_q <= mem_q[rd_index_i][rd_way_i];
    end else if (pkt_yumi_o) begin
      mem_q[pkt_i.index][pkt_i.way_id] <= pkt_i.data;
    end
  end

  assign rd_data_o = rd_data_q;  // holds the last read.

endmodule

`default_nettype wire

// ==== hdl/icache_lce.sv ====
/*
 * Instruction-cache LCE top. Connects the miss FSM, the wait timer,
 * the request and response FIFOs, the response converter and the data memory.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lce_defines.svh"

module icache_lce
  import lce_msg_pkg::*;
  import icache_pkg::*;
(
  input  wire logic                        clk_i,
  input  wire logic                        arst_n_i,

  // miss from the cache.
  input  wire logic                        miss_v_i,
  output logic                             miss_ready_o,
  input  wire logic [`LCE_ADDR_WIDTH-1:0]  miss_addr_i,
  input  wire logic [`LCE_WAY_WIDTH-1:0]   miss_way_i,

  // request to the network.
  output logic                             lce_req_v_o,
  input  wire logic                        lce_req_ready_i,
  output lce_req_t                         lce_req_o,

  // transfer response from the network.
  input  wire logic                        lce_tr_resp_v_i,
  output logic                             lce_tr_resp_ready_o,
  input  wire lce_tr_resp_t                lce_tr_resp_i,

  output logic                             fill_done_o,
  output logic                             miss_error_o,

  // observation read port.
  input  wire logic                        rd_v_i,
  input  wire logic [`LCE_INDEX_WIDTH-1:0] rd_index_i,
  input  wire logic [`LCE_WAY_WIDTH-1:0]   rd_way_i,
  output logic [`LCE_DATA_WIDTH-1:0]       rd_data_o
);

  logic          req_v;
  logic          req_ready;
  lce_req_t      req;
  logic          timer_start;
  logic          timer_en;
  logic          timer_expired;
  logic          tr_received;
  logic          resp_v;
  logic          resp_yumi;
  lce_tr_resp_t  resp;
  logic          pkt_v;
  logic          pkt_yumi;
  data_mem_pkt_t pkt;

  lce_miss_fsm u_miss_fsm (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .miss_v_i        (miss_v_i),
    .miss_ready_o    (miss_ready_o),
    .miss_addr_i     (miss_addr_i),
    .miss_way_i      (miss_way_i),
    .req_v_o         (req_v),
    .req_ready_i     (req_ready),
    .req_o           (req),
    .tr_received_i   (tr_received),
    .timer_start_o   (timer_start),
    .timer_en_o      (timer_en),
    .timer_expired_i (timer_expired),
    .fill_done_o     (fill_done_o),
    .miss_error_o    (miss_error_o)
  );

  lce_timer u_timer (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .start_i   (timer_start),
    .en_i      (timer_en),
    .expired_o (timer_expired)
  );

  // network side is valid/ready, so yumi is ready taken with valid.
  lce_fifo #(.elem_t(lce_req_t)) u_req_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (req_v),
    .ready_o  (req_ready),
    .data_i   (req),
    .v_o      (lce_req_v_o),
    .yumi_i   (lce_req_ready_i & lce_req_v_o),
    .data_o   (lce_req_o)
  );

  lce_fifo #(.elem_t(lce_tr_resp_t)) u_resp_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (lce_tr_resp_v_i),
    .ready_o  (lce_tr_resp_ready_o),
    .data_i   (lce_tr_resp_i),
    .v_o      (resp_v),
    .yumi_i   (resp_yumi),
    .data_o   (resp)
  );

  lce_tr_resp_in u_tr_resp_in (
    .lce_tr_resp_i       (resp),
    .lce_tr_resp_v_i     (resp_v),
    .lce_tr_resp_yumi_o  (resp_yumi),
    .data_mem_pkt_v_o    (pkt_v),
    .data_mem_pkt_o      (pkt),
    .data_mem_pkt_yumi_i (pkt_yumi),
    .tr_received_o       (tr_received)
  );

  icache_data_mem u_data_mem (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .pkt_v_i    (pkt_v),
    .pkt_i      (pkt),
    .pkt_yumi_o (pkt_yumi),
    .rd_v_i     (rd_v_i),
    .rd_index_i (rd_index_i),
    .rd_way_i   (rd_way_i),
    .rd_data_o  (rd_data_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_icache_lce.sv ====
/*
 * Testbench for the instruction-cache LCE. Directed tests for the miss
 * request, fills with read-back, back-pressure and the miss timeout.
 */
`timescale 1ns/1ps
`default_nettype none

`include "lce_defines.svh"

module tb_icache_lce
  import lce_msg_pkg::*;
();

  localparam int wait_limit_lp = 200;  // wait limit in cycles beyond the miss timeout.

  logic                        clk;
  logic                        arst_n;
  logic                        miss_v;
  logic                        miss_ready;
  logic [`LCE_ADDR_WIDTH-1:0]  miss_addr;
  logic [`LCE_WAY_WIDTH-1:0]   miss_way;
  logic                        req_v;
  logic                        req_ready;
  lce_req_t                    req;
  logic                        resp_v;
  logic                        resp_ready;
  lce_tr_resp_t                resp;
  logic                        fill_done;
  logic                        miss_error;
  logic                        rd_v;
  logic [`LCE_INDEX_WIDTH-1:0] rd_index;
  logic [`LCE_WAY_WIDTH-1:0]   rd_way;
  logic [`LCE_DATA_WIDTH-1:0]  rd_data;

  logic [`LCE_DATA_WIDTH-1:0]  model_mem [`LCE_SETS][`LCE_WAYS];  // expected contents.
  int                          seed;
  int                          req_errors;
  int                          data_errors;
  int                          status_errors;
  int                          timeout_errors;

  icache_lce dut (
    .clk_i               (clk),
    .arst_n_i            (arst_n),
    .miss_v_i            (miss_v),
    .miss_ready_o        (miss_ready),
    .miss_addr_i         (miss_addr),
    .miss_way_i          (miss_way),
    .lce_req_v_o         (req_v),
    .lce_req_ready_i     (req_ready),
    .lce_req_o           (req),
    .lce_tr_resp_v_i     (resp_v),
    .lce_tr_resp_ready_o (resp_ready),
    .lce_tr_resp_i       (resp),
    .fill_done_o         (fill_done),
    .miss_error_o        (miss_error),
    .rd_v_i              (rd_v),
    .rd_index_i          (rd_index),
    .rd_way_i            (rd_way),
    .rd_data_o           (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // set index is the address field just above the byte offset.
  function automatic logic [`LCE_INDEX_WIDTH-1:0] index_of_addr(
    input logic [`LCE_ADDR_WIDTH-1:0] addr
  );
    return addr[`LCE_BLOCK_OFFSET_WIDTH +: `LCE_INDEX_WIDTH];
  endfunction

  function automatic logic [`LCE_ADDR_WIDTH-1:0] random_addr();
    return $random(seed);
  endfunction

  function automatic logic [`LCE_WAY_WIDTH-1:0] random_way();
    return `LCE_WAY_WIDTH'($random(seed));
  endfunction

  function automatic logic [`LCE_DATA_WIDTH-1:0] random_data();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic check_req(input string name, input lce_req_t got, input lce_req_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      req_errors++;
    end
  endtask

  task automatic check_data(input string name, input logic [`LCE_DATA_WIDTH-1:0] got,
                            input logic [`LCE_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      data_errors++;
    end
  endtask

  task automatic check_status(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
      status_errors++;
    end
  endtask

  task automatic send_miss(input logic [`LCE_ADDR_WIDTH-1:0] addr,
                           input logic [`LCE_WAY_WIDTH-1:0] way);
    int n;
    n = 0;
    @(posedge clk);
    miss_v    <= 1'b1;
    miss_addr <= addr;
    miss_way  <= way;
    @(negedge clk);
    while (!miss_ready && n < wait_limit_lp) begin
      @(negedge clk);
      n++;
    end
    if (!miss_ready) begin
      $display("timeout at %0t: the miss was never accepted", $time);
      timeout_errors++;
    end
    @(posedge clk);  // transfer happens on this edge.
    miss_v <= 1'b0;
  endtask

  task automatic expect_req(input lce_req_t exp);
    int n;
    n = 0;
    @(negedge clk);
    while (!req_v && n < wait_limit_lp) begin
      @(negedge clk);
      n++;
    end
    if (!req_v) begin
      $display("timeout at %0t: no request appeared on the network", $time);
      timeout_errors++;
    end else begin
      check_req("lce_req_o", req, exp);
    end
  endtask

  task automatic send_resp(input logic [`LCE_ADDR_WIDTH-1:0] addr,
                           input logic [`LCE_WAY_WIDTH-1:0] way,
                           input logic [`LCE_DATA_WIDTH-1:0] data);
    lce_tr_resp_t msg;
    int           n;
    msg.addr   = addr;
    msg.way_id = way;
    msg.data   = data;
    n = 0;
    @(posedge clk);
    resp_v <= 1'b1;
    resp   <= msg;
    @(negedge clk);
    while (!resp_ready && n < wait_limit_lp) begin
      @(negedge clk);
      n++;
    end
    if (!resp_ready) begin
      $display("timeout at %0t: the response was never accepted", $time);
      timeout_errors++;
    end
    @(posedge clk);
    resp_v <= 1'b0;
  endtask

  // the miss stays pending until the one fill pulse.
  task automatic wait_fill();
    int n;
    n = 0;
    @(negedge clk);
    while (!fill_done && n < wait_limit_lp) begin
      check_status("miss_ready_o", miss_ready, 1'b0);
      check_status("miss_error_o", miss_error, 1'b0);
      @(negedge clk);
      n++;
    end
    if (!fill_done) begin
      $display("timeout at %0t: fill_done_o never pulsed", $time);
      timeout_errors++;
    end
    @(negedge clk);
    check_status("fill_done_o", fill_done, 1'b0);
  endtask

  task automatic read_back(input logic [`LCE_INDEX_WIDTH-1:0] index,
                           input logic [`LCE_WAY_WIDTH-1:0] way,
                           input logic [`LCE_DATA_WIDTH-1:0] exp);
    @(posedge clk);
    rd_v     <= 1'b1;
    rd_index <= index;
    rd_way   <= way;
    @(posedge clk);
    rd_v <= 1'b0;
    @(negedge clk);  // data is one cycle after the read.
    check_data("rd_data_o", rd_data, exp);
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_status("lce_req_v_o", req_v, 1'b0);
    check_status("fill_done_o", fill_done, 1'b0);
    check_status("miss_error_o", miss_error, 1'b0);
    check_status("miss_ready_o", miss_ready, 1'b1);
  endtask

  task automatic test_miss_and_fill();
    logic [`LCE_ADDR_WIDTH-1:0] addr;
    logic [`LCE_WAY_WIDTH-1:0]  way;
    logic [`LCE_DATA_WIDTH-1:0] data;
    lce_req_t                   exp;
    addr = random_addr();
    way  = random_way();
    data = random_data();
    exp.addr   = addr;
    exp.way_id = way;
    exp.src_id = `LCE_ID_WIDTH'(`LCE_ID);
    send_miss(addr, way);
    expect_req(exp);
    send_resp(addr, way, data);
    wait_fill();
    model_mem[index_of_addr(addr)][way] = data;
    read_back(index_of_addr(addr), way, data);
  endtask

  task automatic test_back_pressure();
    logic [`LCE_ADDR_WIDTH-1:0] addr_a;
    logic [`LCE_ADDR_WIDTH-1:0] addr_b;
    logic [`LCE_WAY_WIDTH-1:0]  way_a;
    logic [`LCE_WAY_WIDTH-1:0]  way_b;
    logic [`LCE_DATA_WIDTH-1:0] data_a;
    logic [`LCE_DATA_WIDTH-1:0] data_b;
    lce_req_t                   exp;
    int                         n;
    addr_a = random_addr();
    addr_b = addr_a ^ (`LCE_ADDR_WIDTH'(1) << `LCE_BLOCK_OFFSET_WIDTH);  // next set.
    way_a  = random_way();
    way_b  = random_way();
    data_a = random_data();
    data_b = random_data();
    exp.addr   = addr_a;
    exp.way_id = way_a;
    exp.src_id = `LCE_ID_WIDTH'(`LCE_ID);
    @(posedge clk);
    req_ready <= 1'b0;
    send_miss(addr_a, way_a);
    expect_req(exp);
    repeat (5) begin
      @(negedge clk);
      check_status("lce_req_v_o", req_v, 1'b1);
      check_req("lce_req_o", req, exp);
    end
    @(posedge clk);
    req_ready <= 1'b1;
    n = 0;
    @(negedge clk);
    while (req_v && n < wait_limit_lp) begin
      @(negedge clk);
      n++;
    end
    if (req_v) begin
      $display("timeout at %0t: the request was never taken", $time);
      timeout_errors++;
    end
    // reads hold off the fill, so both responses stay queued.
    @(posedge clk);
    rd_v     <= 1'b1;
    rd_index <= '0;
    rd_way   <= '0;
    send_resp(addr_a, way_a, data_a);
    send_resp(addr_b, way_b, data_b);
    @(negedge clk);
    check_status("lce_tr_resp_ready_o", resp_ready, 1'b0);
    check_status("fill_done_o", fill_done, 1'b0);
    @(posedge clk);
    rd_v <= 1'b0;
    wait_fill();
    model_mem[index_of_addr(addr_a)][way_a] = data_a;
    model_mem[index_of_addr(addr_b)][way_b] = data_b;
    read_back(index_of_addr(addr_a), way_a, model_mem[index_of_addr(addr_a)][way_a]);
    read_back(index_of_addr(addr_b), way_b, model_mem[index_of_addr(addr_b)][way_b]);
  endtask

  task automatic test_timeout();
    logic [`LCE_ADDR_WIDTH-1:0] addr;
    logic [`LCE_WAY_WIDTH-1:0]  way;
    logic [`LCE_DATA_WIDTH-1:0] data;
    lce_req_t                   exp;
    int                         n;
    addr = random_addr();
    way  = random_way();
    exp.addr   = addr;
    exp.way_id = way;
    exp.src_id = `LCE_ID_WIDTH'(`LCE_ID);
    send_miss(addr, way);
    expect_req(exp);
    n = 0;
    @(negedge clk);
    while (!miss_error && n < wait_limit_lp) begin
      check_status("fill_done_o", fill_done, 1'b0);
      check_status("miss_ready_o", miss_ready, 1'b0);
      @(negedge clk);
      n++;
    end
    if (!miss_error) begin
      $display("timeout at %0t: miss_error_o never pulsed", $time);
      timeout_errors++;
    end else if (n != `LCE_TIMEOUT_CYCLES) begin
      $display("error at %0t: miss_error_o delay is %0d cycles, expected %0d",
               $time, n, `LCE_TIMEOUT_CYCLES);
      status_errors++;
    end
    @(negedge clk);
    check_status("miss_error_o", miss_error, 1'b0);
    check_status("miss_ready_o", miss_ready, 1'b1);
    // a late block still lands in memory without a pulse.
    data = random_data();
    send_resp(addr, way, data);
    repeat (4) begin
      @(negedge clk);
      check_status("fill_done_o", fill_done, 1'b0);
    end
    model_mem[index_of_addr(addr)][way] = data;
    read_back(index_of_addr(addr), way, data);
  endtask

  task automatic test_several_fills();
    logic [`LCE_ADDR_WIDTH-1:0] addr;
    logic [`LCE_WAY_WIDTH-1:0]  way;
    logic [`LCE_DATA_WIDTH-1:0] data;
    lce_req_t                   exp;
    for (int i = 0; i < 4; i++) begin
      addr = random_addr();
      addr[`LCE_BLOCK_OFFSET_WIDTH + `LCE_INDEX_WIDTH - 2 +: 2] = 2'(i);  // a set per fill.
      way  = random_way();
      data = random_data();
      exp.addr   = addr;
      exp.way_id = way;
      exp.src_id = `LCE_ID_WIDTH'(`LCE_ID);
      send_miss(addr, way);
      expect_req(exp);
      send_resp(addr, way, data);
      wait_fill();
      model_mem[index_of_addr(addr)][way] = data;
    end
    for (int s = 0; s < `LCE_SETS; s++) begin
      for (int w = 0; w < `LCE_WAYS; w++) begin
        read_back(`LCE_INDEX_WIDTH'(s), `LCE_WAY_WIDTH'(w), model_mem[s][w]);
      end
    end
  endtask

  initial begin
    seed           = 92;
    req_errors     = 0;
    data_errors    = 0;
    status_errors  = 0;
    timeout_errors = 0;
    for (int s = 0; s < `LCE_SETS; s++) begin
      for (int w = 0; w < `LCE_WAYS; w++) begin
        model_mem[s][w] = '0;  // memory clears at reset.
      end
    end
    arst_n    <= 1'b0;
    miss_v    <= 1'b0;
    miss_addr <= '0;
    miss_way  <= '0;
    req_ready <= 1'b1;
    resp_v    <= 1'b0;
    resp      <= '0;
    rd_v      <= 1'b0;
    rd_index  <= '0;
    rd_way    <= '0;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    test_reset_state();
    test_miss_and_fill();
    test_back_pressure();
    test_timeout();
    test_several_fills();
    $display("errors: %0d request, %0d data, %0d status, %0d timeout",
             req_errors, data_errors, status_errors, timeout_errors);
    if (req_errors + data_errors + status_errors + timeout_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== icache_lce.f ====
+incdir+hdl
hdl/lce_msg_pkg.sv
hdl/icache_pkg.sv
hdl/lce_fifo.sv
hdl/lce_tr_resp_in.sv
hdl/lce_timer.sv
hdl/lce_miss_fsm.sv
hdl/icache_data_mem.sv
hdl/icache_lce.sv
testbench/tb_icache_lce.sv

// ==== Bender.yml ====
package:
  name: icache_lce

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lce_msg_pkg.sv
      - hdl/icache_pkg.sv
      - hdl/lce_fifo.sv
      - hdl/lce_tr_resp_in.sv
      - hdl/lce_timer.sv
      - hdl/lce_miss_fsm.sv
      - hdl/icache_data_mem.sv
      - hdl/icache_lce.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_icache_lce.sv
